// File: files.f
include/frontend_pkg.sv
verilog/inst_mem.sv
verilog/mem_arbiter.sv
verilog/inst_fetch.sv
verilog/inst_queue.sv
verilog/frontend_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top \
    -f files.f --Mdir obj_dir -o sim_frontend
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_frontend)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// File: verif/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int ADDR_W = frontend_pkg::ADDR_W;
    localparam int WORDS  = 2 ** ADDR_W;

    localparam int T5_ENTRIES = 4;              // first entries after reset
    localparam int T1_ENTRIES = 300;            // enough to wrap past pc 255
    localparam int T2_ENTRIES = 400;
    localparam int T3_ROUNDS  = 20;             // up to 16 entries before each redirect
    localparam int T4_PHASES  = 8;              // up to 64 load cycles and 39 entries each

    // two cycles allowed per checked entry, one per load or redirect
    localparam int STIM_CYCLES = 4 + 2 * T5_ENTRIES + WORDS + 1 + 2 * T1_ENTRIES
                               + 2 * T2_ENTRIES + T3_ROUNDS * (1 + 2 * 16) + 2 * 4
                               + T4_PHASES * (64 + 1 + 2 * 39);
    localparam int LIMIT = 4 * STIM_CYCLES;

    logic                            clk;
    logic                            reset;
    logic                            load_strobe;
    logic [ADDR_W-1:0]               load_addr;
    logic [frontend_pkg::INST_W-1:0] load_data;
    logic                            redirect;
    logic [ADDR_W-1:0]               redirect_pc;
    logic [1:0]                      deq_take;
    frontend_pkg::fetch_entry_t      deq_entry0;
    frontend_pkg::fetch_entry_t      deq_entry1;
    logic [1:0]                      deq_count;

    logic [frontend_pkg::INST_W-1:0] model_mem [WORDS];    // what memory should hold
    logic [31:0]                     lfsr = 32'h9ccd;
    int                              test_id;
    int                              errors;
    int                              checked;
    int                              cycles = 0;

    frontend_top #(.ADDR_W(ADDR_W), .QDEPTH(frontend_pkg::QDEPTH)) uut (
        .clk         (clk),
        .reset       (reset),
        .load_strobe (load_strobe),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .deq_take    (deq_take),
        .deq_entry0  (deq_entry0),
        .deq_entry1  (deq_entry1),
        .deq_count   (deq_count)
    );

    tb_checker #(.ADDR_W(ADDR_W)) u_checker (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .deq_take    (deq_take),
        .deq_entry0  (deq_entry0),
        .deq_entry1  (deq_entry1),
        .deq_count   (deq_count),
        .test_id     (test_id),
        .model_mem   (model_mem),
        .errors      (errors),
        .checked     (checked)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
    endfunction

    // one lfsr step per bit, lsb first into the low end
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    task automatic drive_load(input logic [ADDR_W-1:0] a, input logic [31:0] d);
        load_strobe  = 1'b1;
        load_addr    = a;
        load_data    = d;
        model_mem[a] = d;                       // model follows every store
    endtask

    task automatic load_cycle(input logic [ADDR_W-1:0] a, input logic [31:0] d);
        @(negedge clk);
        deq_take = 2'd0;                        // queue held idle while loading
        redirect = 1'b0;
        drive_load(a, d);
    endtask

    task automatic gap_cycle();
        @(negedge clk);
        deq_take    = 2'd0;
        redirect    = 1'b0;
        load_strobe = 1'b0;                     // lets a fetch through, flushed later
    endtask

    task automatic redirect_cycle(input logic [ADDR_W-1:0] pc);
        @(negedge clk);
        deq_take    = 2'd0;
        load_strobe = 1'b0;
        redirect    = 1'b1;
        redirect_pc = pc;
    endtask

    task automatic decode_cycle(input bit random_take, input bit contend);
        logic [31:0]       bits;
        logic [1:0]        want;
        logic [ADDR_W-1:0] a;
        @(negedge clk);
        bits        = take_bits(random_take ? 2 : 0);
        want        = random_take ? bits[1:0] : 2'd2;
        deq_take    = (want > deq_count) ? deq_count : want;   // never past the head
        redirect    = 1'b0;
        load_strobe = 1'b0;
        if (contend) begin
            bits = take_bits(3);
            if (bits[2:0] == 3'd0) begin
                bits = take_bits(ADDR_W);
                a    = bits[ADDR_W-1:0];
                drive_load(a, model_mem[a]);    // same word again, only steals the port
            end
        end
    endtask

    task automatic drain(input int n, input bit random_take, input bit contend);
        int target;
        target = checked + n;
        while (checked < target) begin
            decode_cycle(random_take, contend);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run stopped after %0d cycles with tests unfinished", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] bits;
        logic [31:0] word;
        int          n;
        reset       = 1'b1;
        load_strobe = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        deq_take    = 2'd0;
        test_id     = 5;
        model_mem   = '{default: '0};           // memory powers up cleared
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // fetch starts at pc 0 on its own
        drain(T5_ENTRIES, 1'b0, 1'b0);

        test_id = 1;
        for (int a = 0; a < WORDS; a++) begin
            word = take_bits(32);
            load_cycle(ADDR_W'(a), word);
        end
        redirect_cycle('0);
        drain(T1_ENTRIES, 1'b0, 1'b0);

        test_id = 2;
        drain(T2_ENTRIES, 1'b1, 1'b0);          // continues the same stream

        test_id = 3;
        for (int r = 0; r < T3_ROUNDS; r++) begin
            bits = take_bits(4);
            drain(int'(bits[3:0]) + 1, 1'b1, 1'b0);
            bits = take_bits(ADDR_W);
            redirect_cycle(bits[ADDR_W-1:0]);   // queue usually partly full here
        end
        drain(4, 1'b1, 1'b0);

        test_id = 4;
        for (int p = 0; p < T4_PHASES; p++) begin
            bits = take_bits(5);
            n    = int'(bits[4:0]) + 1;
            for (int i = 0; i < n; i++) begin
                bits = take_bits(2);
                if (bits[1:0] == 2'd0) begin
                    gap_cycle();
                end
                bits = take_bits(ADDR_W);
                word = take_bits(32);
                load_cycle(bits[ADDR_W-1:0], word);
            end
            bits = take_bits(ADDR_W);
            redirect_cycle(bits[ADDR_W-1:0]);
            bits = take_bits(5);
            drain(int'(bits[4:0]) + 8, 1'b1, 1'b1);
        end

        @(negedge clk);
        deq_take    = 2'd0;
        load_strobe = 1'b0;
        @(negedge clk);
        $display("errors: %0d, entries checked: %0d, cycles: %0d", errors, checked, cycles);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
    parameter int ADDR_W = 8
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             redirect,
    input  logic [ADDR_W-1:0]                redirect_pc,
    input  logic [1:0]                       deq_take,
    input  frontend_pkg::fetch_entry_t       deq_entry0,
    input  frontend_pkg::fetch_entry_t       deq_entry1,
    input  logic [1:0]                       deq_count,
    input  int                               test_id,
    input  logic [frontend_pkg::INST_W-1:0]  model_mem [2**ADDR_W],
    output int                               errors,
    output int                               checked
);

    logic [ADDR_W-1:0] exp_pc;                  // next pc decode should see
    logic              expect_empty;            // queue was just reset or flushed

    function automatic string test_name(input int id);
        case (id)
            1:       return "program_load";
            2:       return "random_decode";
            3:       return "redirect";
            4:       return "load_contention";
            5:       return "reset_state";
            default: return "unknown";
        endcase
    endfunction

    // one entry leaving the queue head, compared against the model stream
    task automatic check_entry(input frontend_pkg::fetch_entry_t got);
        logic [frontend_pkg::INST_W-1:0] exp_inst;
        exp_inst = model_mem[exp_pc];
        if (got.pc !== exp_pc) begin
            $display("FAIL %s entry pc: expected %0d, actual %0d",
                     test_name(test_id), exp_pc, got.pc);
            errors = errors + 1;
        end
        if (got.inst !== exp_inst) begin
            $display("FAIL %s inst at pc %0d: expected %08h, actual %08h",
                     test_name(test_id), exp_pc, exp_inst, got.inst);
            errors = errors + 1;
        end
        exp_pc  = exp_pc + ADDR_W'(1);          // wraps 255 -> 0 like fetch
        checked = checked + 1;
    endtask

    // sampled at the edge, so these are the values decode saw in the cycle
    always @(posedge clk) begin
        if (reset) begin
            exp_pc       = '0;                  // fetch restarts at 0
            expect_empty = 1'b1;
            errors       = 0;
            checked      = 0;
        end else begin
            if (expect_empty && (deq_count != 2'd0)) begin
                $display("FAIL %s deq_count after reset or flush: expected 0, actual %0d",
                         test_name(test_id), deq_count);
                errors = errors + 1;
            end
            expect_empty = 1'b0;
            if (deq_count == 2'd3) begin
                $display("FAIL %s deq_count: expected at most 2, actual %0d",
                         test_name(test_id), deq_count);
                errors = errors + 1;
            end
            if (redirect) begin
                exp_pc       = redirect_pc;     // new stream, old entries are gone
                expect_empty = 1'b1;
            end else begin
                if (deq_take >= 2'd1) begin
                    check_entry(deq_entry0);
                end
                if (deq_take == 2'd2) begin
                    check_entry(deq_entry1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
    parameter int ADDR_W = frontend_pkg::ADDR_W,
    parameter int QDEPTH = frontend_pkg::QDEPTH
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              load_strobe,
    input  logic [ADDR_W-1:0]                 load_addr,
    input  logic [frontend_pkg::INST_W-1:0]   load_data,
    input  logic                              redirect,
    input  logic [ADDR_W-1:0]                 redirect_pc,
    input  logic [1:0]                        deq_take,
    output frontend_pkg::fetch_entry_t        deq_entry0,
    output frontend_pkg::fetch_entry_t        deq_entry1,
    output logic [1:0]                        deq_count
);

    frontend_pkg::mem_req_t     load_req;       // loader write, built from the port pins
    frontend_pkg::mem_req_t     fetch_req;      // paired read from fetch
    frontend_pkg::mem_req_t     mem_req;        // winner on the memory port
    frontend_pkg::mem_rsp_t     mem_rsp;        // raw read data
    frontend_pkg::mem_rsp_t     fetch_rsp;      // read data that belongs to fetch
    logic                       fetch_grant;
    logic                       fetch_room;
    logic [1:0]                 enq_en;
    frontend_pkg::fetch_entry_t enq_entry0;
    frontend_pkg::fetch_entry_t enq_entry1;

    assign load_req = '{valid: load_strobe, write: 1'b1, addr: load_addr, wdata: load_data};

    mem_arbiter #(.ADDR_W(ADDR_W)) u_arbiter (
        .clk         (clk),
        .reset       (reset),
        .load_req    (load_req),
        .fetch_req   (fetch_req),
        .fetch_grant (fetch_grant),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .fetch_rsp   (fetch_rsp)
    );

    inst_mem #(.ADDR_W(ADDR_W)) u_mem (
        .clk (clk),
        .req (mem_req),
        .rsp (mem_rsp)
    );

    inst_fetch #(.ADDR_W(ADDR_W)) u_fetch (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_room  (fetch_room),
        .fetch_req   (fetch_req),
        .fetch_grant (fetch_grant),
        .fetch_rsp   (fetch_rsp),
        .enq_en      (enq_en),
        .enq_entry0  (enq_entry0),
        .enq_entry1  (enq_entry1)
    );

    // redirect doubles as the queue flush
    inst_queue #(
        .DEPTH   (QDEPTH),
        .entry_t (frontend_pkg::fetch_entry_t)
    ) u_queue (
        .clk        (clk),
        .reset      (reset),
        .flush      (redirect),
        .enq_en     (enq_en),
        .enq_entry0 (enq_entry0),
        .enq_entry1 (enq_entry1),
        .deq_take   (deq_take),
        .deq_entry0 (deq_entry0),
        .deq_entry1 (deq_entry1),
        .deq_count  (deq_count),
        .fetch_room (fetch_room)
    );

endmodule

`default_nettype wire

// File: verilog/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
    parameter int  DEPTH   = 8,
    parameter type entry_t = frontend_pkg::fetch_entry_t
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic [1:0] enq_en,
    input  entry_t     enq_entry0,
    input  entry_t     enq_entry1,
    input  logic [1:0] deq_take,
    output entry_t     deq_entry0,
    output entry_t     deq_entry1,
    output logic [1:0] deq_count,
    output logic       fetch_room
);

    localparam int PTR_W = $clog2(DEPTH);       // pointers wrap at DEPTH
    localparam int CNT_W = PTR_W + 1;           // count holds 0..DEPTH

    // pointer wrap relies on a power of two, fetch_room needs at least four slots
    if ((DEPTH != (2 ** PTR_W)) || (DEPTH < 4)) begin : g_depth_check
        $error("inst_queue: DEPTH must be a power of two and at least 4");
    end

    entry_t ram [DEPTH];                        // slot storage

    logic [PTR_W-1:0] head;                     // oldest entry
    logic [PTR_W-1:0] tail;                     // next free slot
    logic [CNT_W-1:0] count;                    // entries held
    logic [CNT_W-1:0] free_slots;

    logic [1:0]       enq_n;                    // entries written this cycle
    logic [PTR_W-1:0] head_nx1;                 // second entry at the head
    logic [PTR_W-1:0] tail_nx1;                 // slot after tail
    logic [PTR_W-1:0] wr1_ptr;                  // where enq_entry1 lands

    assign enq_n    = {1'b0, enq_en[0]} + {1'b0, enq_en[1]};
    assign head_nx1 = head + PTR_W'(1);
    assign tail_nx1 = tail + PTR_W'(1);
    assign wr1_ptr  = enq_en[0] ? tail_nx1 : tail;  // packs if entry0 absent

    assign free_slots = CNT_W'(DEPTH) - count;

    // payload writes, no reset on the slots
    always_ff @(posedge clk) begin
        if (!flush) begin
            if (enq_en[0]) begin
                ram[tail] <= enq_entry0;
            end
            if (enq_en[1]) begin
                ram[wr1_ptr] <= enq_entry1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;                        // empty the queue
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PTR_W'(deq_take);   // release 0..2
            tail  <= tail + PTR_W'(enq_n);      // accept 0..2
            count <= count + CNT_W'(enq_n) - CNT_W'(deq_take);
        end
    end

    assign deq_entry0 = ram[head];
    assign deq_entry1 = ram[head_nx1];
    assign deq_count  = (count >= CNT_W'(2)) ? 2'd2 : count[1:0];  // decode sees two at most

    // room for the pair in flight and one more pair
    assign fetch_room = free_slots >= CNT_W'(4);

    // fetch must stay inside the room it reserved
    a_no_overflow : assert property (@(posedge clk) disable iff (reset || flush)
        (enq_n != 2'd0) |-> (CNT_W'(enq_n) <= free_slots + CNT_W'(deq_take)))
        else $error("inst_queue: enqueue overflow");

    // decode only takes what the previous edge made visible
    a_no_underflow : assert property (@(posedge clk) disable iff (reset || flush)
        deq_take <= deq_count)
        else $error("inst_queue: dequeue of absent entries");

endmodule

`default_nettype wire

// File: verilog/inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fetch #(
    parameter int ADDR_W = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          redirect,
    input  logic [ADDR_W-1:0]             redirect_pc,
    input  logic                          fetch_room,
    output frontend_pkg::mem_req_t        fetch_req,
    input  logic                          fetch_grant,
    input  frontend_pkg::mem_rsp_t        fetch_rsp,
    output logic [1:0]                    enq_en,
    output frontend_pkg::fetch_entry_t    enq_entry0,
    output frontend_pkg::fetch_entry_t    enq_entry1
);

    logic [ADDR_W-1:0] pc;                      // next pair to fetch
    logic              epoch;                   // flips on every redirect
    logic [ADDR_W-1:0] fl_pc;                   // pc of the read in flight
    logic              fl_epoch;                // epoch it was issued under
    logic [ADDR_W-1:0] fl_pc_nx;                // pc of the second word
    logic              rsp_live;                // response belongs to current stream

    // ask for a pair only when the queue has reserved room for it
    assign fetch_req = '{
        valid: fetch_room && !redirect,
        write: 1'b0,
        addr:  pc,
        wdata: '0
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= '0;
            epoch <= 1'b0;
        end else if (redirect) begin
            pc    <= redirect_pc;               // restart the stream
            epoch <= ~epoch;                    // kills whatever is in flight
        end else if (fetch_grant) begin
            pc    <= pc + ADDR_W'(2);           // pair accepted
        end
        // a denied request keeps the same pc and retries
    end

    always_ff @(posedge clk) begin
        if (fetch_grant) begin
            fl_pc    <= pc;                     // tag for the returning pair
            fl_epoch <= epoch;
        end
    end

    assign fl_pc_nx = fl_pc + ADDR_W'(1);       // wraps with the memory
    assign rsp_live = fetch_rsp.valid && (fl_epoch == epoch) && !redirect;

    assign enq_en     = {rsp_live, rsp_live};   // always a full pair
    assign enq_entry0 = '{pc: fl_pc,    inst: fetch_rsp.data0};
    assign enq_entry1 = '{pc: fl_pc_nx, inst: fetch_rsp.data1};

    // a granted read comes back through the arbiter on the very next cycle
    a_grant_rsp : assert property (@(posedge clk) disable iff (reset)
        fetch_grant |=> fetch_rsp.valid)
        else $error("inst_fetch: granted read returned no data");

endmodule

`default_nettype wire

// File: verilog/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
    parameter int ADDR_W = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  frontend_pkg::mem_req_t load_req,
    input  frontend_pkg::mem_req_t fetch_req,
    output logic                   fetch_grant,
    output frontend_pkg::mem_req_t mem_req,
    input  frontend_pkg::mem_rsp_t mem_rsp,
    output frontend_pkg::mem_rsp_t fetch_rsp
);

    // the request structs carry the package address width
    if (ADDR_W != frontend_pkg::ADDR_W) begin : g_addr_check
        $error("mem_arbiter: ADDR_W differs from the request struct width");
    end

    logic load_grant;                           // loader owns the port
    logic fetch_pend;                           // last granted access was a fetch read

    assign load_grant  = load_req.valid;                        // loader always wins
    assign fetch_grant = fetch_req.valid && !load_req.valid;    // fetch only when port is free

    always_comb begin
        mem_req = '0;                           // idle port
        if (load_grant) begin
            mem_req = load_req;
        end else if (fetch_grant) begin
            mem_req = fetch_req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pend <= 1'b0;
        end else begin
            fetch_pend <= fetch_grant;          // response lands one cycle later
        end
    end

    // only read data that fetch asked for goes back to it
    assign fetch_rsp = fetch_pend ? mem_rsp : '0;

    // loader and fetch never share a grant, and a loader slot never feeds fetch
    a_one_grant : assert property (@(posedge clk) disable iff (reset)
        load_grant |-> !fetch_grant ##1 !fetch_rsp.valid)
        else $error("mem_arbiter: loader and fetch both granted");

endmodule

`default_nettype wire

// File: verilog/inst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module inst_mem #(
    parameter int ADDR_W = 8
) (
    input  logic                  clk,
    input  frontend_pkg::mem_req_t req,
    output frontend_pkg::mem_rsp_t rsp
);

    localparam int WORDS = 2 ** ADDR_W;         // full address space

    // program store, starts out all zero
    logic [frontend_pkg::INST_W-1:0] mem [WORDS] = '{default: '0};

    logic                            rsp_valid = 1'b0;  // read strobe, one cycle
    logic [frontend_pkg::INST_W-1:0] rsp_data0;         // registered word at addr
    logic [frontend_pkg::INST_W-1:0] rsp_data1;         // registered word at addr+1

    logic [ADDR_W-1:0] addr;                    // port address
    logic [ADDR_W-1:0] addr_nx;                 // second word of a pair

    logic rd_en;
    logic wr_en;

    assign addr    = req.addr;
    assign addr_nx = addr + ADDR_W'(1);         // wraps 255 -> 0 on its own
    assign rd_en   = req.valid && !req.write;
    assign wr_en   = req.valid && req.write;

    always_ff @(posedge clk) begin
        rsp_valid <= rd_en;                     // high only in the cycle after a read
        if (wr_en) begin
            mem[addr] <= req.wdata;             // single word store
        end
        if (rd_en) begin
            rsp_data0 <= mem[addr];
            rsp_data1 <= mem[addr_nx];
        end
    end

    assign rsp = '{valid: rsp_valid, data0: rsp_data0, data1: rsp_data1};

    // a store never produces read data on the next cycle
    a_write_no_rsp : assert property (@(posedge clk) wr_en |=> !rsp.valid)
        else $error("inst_mem: response after a write");

endmodule

`default_nettype wire

// File: include/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    // default sizes, the top level hands these down as module parameters
    localparam int ADDR_W = 8;                  // word address width, 256 words
    localparam int INST_W = 32;                 // one instruction word
    localparam int QDEPTH = 8;                  // instruction queue slots

    // one request on the single memory port
    // a read returns addr and addr+1, wrapping at the top of memory
    typedef struct packed {
        logic              valid;               // request present this cycle
        logic              write;               // 1 = store wdata, 0 = paired read
        logic [ADDR_W-1:0] addr;                // word address
        logic [INST_W-1:0] wdata;               // store data, ignored on reads
    } mem_req_t;                                // 42 bits

    // read response, valid for one cycle after the accepting edge
    typedef struct packed {
        logic              valid;               // pair below is good
        logic [INST_W-1:0] data0;               // word at addr
        logic [INST_W-1:0] data1;               // word at addr+1
    } mem_rsp_t;                                // 65 bits

    // what the queue carries toward decode
    typedef struct packed {
        logic [ADDR_W-1:0] pc;                  // word address of the instruction
        logic [INST_W-1:0] inst;                // raw instruction bits
    } fetch_entry_t;                            // 40 bits

endpackage

`default_nettype wire
